/* eeprom_wr.f */
logic/eeprom_pkg.sv
logic/i2c_bit_if.sv
logic/eeprom_req.sv
logic/eeprom_seq.sv
logic/i2c_bit_engine.sv
logic/eeprom_wr.sv
bench/eeprom_model.sv
bench/eeprom_wr_tb.sv

/* bench/eeprom_wr_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_eeprom_wr;

  localparam int CLK_DIV    = 4;
  localparam int PERIOD     = 100;
  localparam int RST_CYCLES = 16;
  localparam int N_TXN      = 60;
  localparam int BIT_CYC    = 4 * CLK_DIV;
  localparam int TXN_LIMIT  = 50 * BIT_CYC; // cycles allowed per transfer
  localparam logic [3:0] DEV_CODE = 4'b1010;

  logic        clk;
  logic        rst;
  logic        wr;
  logic        rd;
  logic [10:0] addr;
  logic [7:0]  wdata;
  wire  [7:0]  rdata;
  wire         ack;
  wire         err;
  wire         busy;
  wire         scl;
  wire         sda;

  logic [7:0]  ref_mem [0:2047];
  logic [15:0] lfsr;
  logic [10:0] cur_addr;
  logic [10:0] last_wr;
  logic [7:0]  ctrl_shift;
  logic        hung;
  int          ctrl_bits;
  int          n_start;
  int          n_stop;
  int          ack_cnt;
  int          value_errs;
  int          other_errs;

  eeprom_wr #(
    .CLK_DIV (CLK_DIV)
  ) eeprom_wr_inst (
    .clk   (clk),
    .rst   (rst),
    .wr    (wr),
    .rd    (rd),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .ack   (ack),
    .err   (err),
    .busy  (busy),
    .scl   (scl),
    .sda   (sda)
  );

  eeprom_model mem_model (
    .scl (scl),
    .sda (sda)
  );

  pullup (sda);

  always #(PERIOD / 2) clk = ~clk;

  always @(posedge ack) ack_cnt = ack_cnt + 1;

  // sda moving under a high scl is a start or a stop
  always @(negedge sda) begin
    if (scl === 1'b1 && rst === 1'b0) begin
      n_start   = n_start + 1;
      ctrl_bits = 0;
    end
  end

  always @(posedge sda) begin
    if (scl === 1'b1 && rst === 1'b0) begin
      n_stop    = n_stop + 1;
      ctrl_bits = 9;
    end
  end

  always @(posedge scl) begin : ctrl_watch
    logic [7:0] exp_ctrl;
    if (ctrl_bits < 8) begin
      ctrl_shift = {ctrl_shift[6:0], sda};
      ctrl_bits  = ctrl_bits + 1;
      if (ctrl_bits == 8) begin
        exp_ctrl = {DEV_CODE, cur_addr[10:8], n_start == 2}; // second start reads
        check_value("ctrl_byte", exp_ctrl, ctrl_shift);
      end
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] got);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      value_errs = value_errs + 1;
    end
  endtask

  task automatic run_txn(input int idx, output logic stuck);
    logic [15:0] r;
    logic        op_read;
    logic        extra;
    logic [10:0] a;
    logic [7:0]  d;
    logic        exp_err;
    int          acks_before;
    int          waited;
    take_bits(1, r);
    op_read = r[0];
    take_bits(11, r);
    a = r[10:0];
    take_bits(8, r);
    d = r[7:0];
    take_bits(2, r);
    extra = r[0];
    if (r[1] && op_read) begin
      a = last_wr; // read back a written byte
    end
    exp_err     = (a[10:8] == 3'b111);
    cur_addr    = a;
    n_start     = 0;
    n_stop      = 0;
    acks_before = ack_cnt;
    wr          = !op_read;
    rd          = op_read;
    addr        = a;
    wdata       = d;
    @(negedge clk);
    wr    = 1'b0;
    rd    = 1'b0;
    addr  = ~a;
    wdata = ~d;
    check_value("busy", 1, busy);
    if (extra) begin
      repeat (20) @(negedge clk);
      check_value("busy", 1, busy);
      wr = op_read; // should be dropped
      rd = !op_read;
      @(negedge clk);
      wr = 1'b0;
      rd = 1'b0;
    end
    waited = 0;
    while (ack !== 1'b1 && waited < TXN_LIMIT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    stuck = (waited >= TXN_LIMIT);
    assert (!stuck) else begin
      $display("transfer %0d got no ack within %0d cycles", idx, TXN_LIMIT);
      other_errs = other_errs + 1;
    end
    if (!stuck) begin
      check_value("err", exp_err, err);
      if (op_read && !exp_err) begin
        check_value("rdata", ref_mem[a], rdata);
      end
      if (!op_read && !exp_err) begin
        ref_mem[a] = d;
        last_wr    = a;
      end
      check_value("start conditions", (op_read && !exp_err) ? 2 : 1, n_start);
      check_value("stop conditions", 1, n_stop);
      @(negedge clk);
      check_value("ack", 0, ack);
      check_value("busy", 0, busy);
      check_value("ack count", acks_before + 1, ack_cnt);
      check_value("scl", 1, scl);
      check_value("sda", 1, sda);
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    wr         = 1'b0;
    rd         = 1'b0;
    addr       = '0;
    wdata      = '0;
    lfsr       = 16'd72;
    cur_addr   = '0;
    last_wr    = '0;
    ctrl_shift = '0;
    hung       = 1'b0;
    ctrl_bits  = 9;
    n_start    = 0;
    n_stop     = 0;
    ack_cnt    = 0;
    value_errs = 0;
    other_errs = 0;
    for (int i = 0; i < 2048; i++) begin
      ref_mem[i] = i[7:0] ^ {i[10:8], 5'b0};
    end
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("scl", 1, scl);
    check_value("sda", 1, sda);
    check_value("ack", 0, ack);
    check_value("err", 0, err);
    check_value("busy", 0, busy);
    for (int t = 0; t < N_TXN && !hung; t++) begin
      run_txn(t, hung);
      @(negedge clk);
    end
    check_value("total acks", N_TXN, ack_cnt);
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((RST_CYCLES + N_TXN * 50 * BIT_CYC) * PERIOD);
    other_errs = other_errs + 1;
    $display("watchdog expired before the last transfer finished");
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/eeprom_model.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_model (
  input wire scl,
  inout wire sda
);

  localparam int ST_IDLE  = 0;
  localparam int ST_CTRL  = 1;
  localparam int ST_ADDR  = 2;
  localparam int ST_WDATA = 3;
  localparam int ST_RDATA = 4;

  logic [7:0] mem [0:2047];
  logic       pull_low; // only ever pulls low
  logic       in_ack;   // ninth clock of a byte
  logic [7:0] shreg;
  logic [2:0] blk;
  logic [7:0] word;
  int         state;
  int         next_st;
  int         bit_cnt;

  assign sda = pull_low ? 1'b0 : 1'bz;

  initial begin
    pull_low = 1'b0;
    in_ack   = 1'b0;
    state    = ST_IDLE;
    next_st  = ST_IDLE;
    bit_cnt  = 0;
    blk      = '0;
    word     = '0;
    for (int i = 0; i < 2048; i++) begin
      mem[i] = i[7:0] ^ {i[10:8], 5'b0}; // block bits folded into the top
    end
  end

  // start condition
  always @(negedge sda) begin
    if (scl === 1'b1) begin
      state    = ST_CTRL;
      bit_cnt  = 0;
      in_ack   = 1'b0;
      pull_low = 1'b0;
    end
  end

  // stop condition
  always @(posedge sda) begin
    if (scl === 1'b1) begin
      state    = ST_IDLE;
      in_ack   = 1'b0;
      pull_low = 1'b0;
    end
  end

  always @(posedge scl) begin
    if (!in_ack && bit_cnt < 8 &&
        (state == ST_CTRL || state == ST_ADDR || state == ST_WDATA)) begin
      shreg   = {shreg[6:0], sda};
      bit_cnt = bit_cnt + 1;
    end
  end

  always @(negedge scl) begin
    if (in_ack) begin
      in_ack   = 1'b0;
      pull_low = 1'b0;
      bit_cnt  = 0;
      state    = next_st;
      if (state == ST_RDATA) begin
        shreg    = mem[{blk, word}];
        pull_low = !shreg[7];
        bit_cnt  = 1;
      end
    end else if (state == ST_RDATA) begin
      if (bit_cnt < 8) begin
        pull_low = !shreg[7 - bit_cnt];
        bit_cnt  = bit_cnt + 1;
      end else begin
        pull_low = 1'b0; // master answers this one
        in_ack   = 1'b1;
        next_st  = ST_IDLE;
      end
    end else if (bit_cnt == 8 && state != ST_IDLE) begin
      take_byte();
    end
  end

  task automatic take_byte();
    in_ack   = 1'b1;
    pull_low = 1'b1;
    case (state)
      ST_CTRL: begin
        if (shreg[7:4] == 4'b1010 && shreg[3:1] != 3'b111) begin
          blk     = shreg[3:1];
          next_st = shreg[0] ? ST_RDATA : ST_ADDR;
        end else begin
          // block 7 and foreign devices stay silent
          in_ack   = 1'b0;
          pull_low = 1'b0;
          state    = ST_IDLE;
        end
      end
      ST_ADDR: begin
        word    = shreg;
        next_st = ST_WDATA;
      end
      default: begin
        mem[{blk, word}] = shreg;
        next_st          = ST_IDLE;
      end
    endcase
  endtask

endmodule

`default_nettype wire

/* logic/eeprom_wr.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_wr #(
  parameter int CLK_DIV = 4
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [eeprom_pkg::ADDR_W-1:0] addr,
  input  logic [eeprom_pkg::DATA_W-1:0] wdata,
  output logic [eeprom_pkg::DATA_W-1:0] rdata,
  output logic                          ack,
  output logic                          err,
  output logic                          busy,
  output logic                          scl,
  inout  wire                           sda
);

  logic                          start;
  logic                          read;
  logic                          done;
  logic [eeprom_pkg::DATA_W-2:0] ctrl_byte;
  logic [eeprom_pkg::DATA_W-1:0] word_addr;
  logic [eeprom_pkg::DATA_W-1:0] wr_byte;
  logic                          sda_oe;

  i2c_bit_if bit_bus ();

  eeprom_req req_inst (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .rd        (rd),
    .addr      (addr),
    .wdata     (wdata),
    .done      (done),
    .busy      (busy),
    .start     (start),
    .read      (read),
    .ctrl_byte (ctrl_byte),
    .word_addr (word_addr),
    .wr_byte   (wr_byte)
  );

  eeprom_seq seq_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .read      (read),
    .ctrl_byte (ctrl_byte),
    .word_addr (word_addr),
    .wr_byte   (wr_byte),
    .bit_bus   (bit_bus.master),
    .busy      (busy),
    .done      (done),
    .ack       (ack),
    .err       (err),
    .rdata     (rdata)
  );

  i2c_bit_engine #(
    .CLK_DIV (CLK_DIV)
  ) engine_inst (
    .clk     (clk),
    .rst     (rst),
    .bit_bus (bit_bus.engine),
    .scl     (scl),
    .sda_oe  (sda_oe),
    .sda_in  (sda)
  );

  // open drain with the pullup outside
  assign sda = sda_oe ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

/* logic/i2c_bit_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine #(
  parameter int CLK_DIV = 4 // clk cycles per scl quarter
) (
  input  logic       clk,
  input  logic       rst,
  i2c_bit_if.engine  bit_bus,
  output logic       scl,
  output logic       sda_oe,
  input  logic       sda_in
);

  localparam int Q_W = $clog2(CLK_DIV);

  eeprom_pkg::bit_cmd_t cmd_r;

  logic                          active;
  logic [Q_W-1:0]                qcnt;
  logic [1:0]                    phase; // scl quarter within the bit
  logic [3:0]                    bitcnt;
  logic [eeprom_pkg::DATA_W-1:0] shift;
  logic [eeprom_pkg::DATA_W-1:0] rx_shift;
  logic                          nack_r;
  logic                          rx_ack_r;
  logic                          scl_hold;
  logic                          oe_hold;
  logic                          scl_ph;
  logic                          oe_ph;
  logic                          q_end;
  logic                          bit_end;
  logic                          ack_bit;
  logic                          one_bit; // start and stop are a single bit
  logic                          load;

  assign q_end   = (qcnt == Q_W'(CLK_DIV - 1));
  assign bit_end = q_end && (phase == 2'd3);
  assign ack_bit = (bitcnt == 4'd8);
  assign one_bit = (cmd_r == eeprom_pkg::cmd_start) || (cmd_r == eeprom_pkg::cmd_stop);

  assign bit_bus.done  = active && bit_end && (one_bit || ack_bit);
  assign bit_bus.ready = !active || bit_bus.done;
  assign load          = bit_bus.ready && (bit_bus.cmd != eeprom_pkg::cmd_none);

  assign bit_bus.rx_byte = rx_shift;
  assign bit_bus.rx_ack  = rx_ack_r;

  // scl and sda per quarter
  always_comb begin
    scl_ph = 1'b0;
    oe_ph  = 1'b0;
    case (cmd_r)
      eeprom_pkg::cmd_start: begin
        scl_ph = (phase == 2'd1) || (phase == 2'd2);
        oe_ph  = phase[1]; // sda falls while scl is high
      end
      eeprom_pkg::cmd_stop: begin
        scl_ph = (phase != 2'd0);
        oe_ph  = !phase[1]; // sda rises while scl is high
      end
      eeprom_pkg::cmd_send: begin
        scl_ph = (phase == 2'd1) || (phase == 2'd2);
        oe_ph  = ack_bit ? 1'b0 : !shift[eeprom_pkg::DATA_W-1];
      end
      eeprom_pkg::cmd_recv: begin
        scl_ph = (phase == 2'd1) || (phase == 2'd2);
        oe_ph  = ack_bit ? !nack_r : 1'b0;
      end
      default: begin
        scl_ph = 1'b1;
        oe_ph  = 1'b0;
      end
    endcase
  end

  // lines keep their last level between commands
  assign scl    = active ? scl_ph : scl_hold;
  assign sda_oe = active ? oe_ph : oe_hold;

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      cmd_r    <= eeprom_pkg::cmd_none;
      qcnt     <= '0;
      phase    <= 2'd0;
      bitcnt   <= 4'd0;
      scl_hold <= 1'b1;
      oe_hold  <= 1'b0;
    end else begin
      scl_hold <= scl;
      oe_hold  <= sda_oe;
      if (load) begin
        active <= 1'b1;
        cmd_r  <= bit_bus.cmd;
        qcnt   <= '0;
        phase  <= 2'd0;
        bitcnt <= 4'd0;
      end else if (bit_bus.done) begin
        active <= 1'b0;
      end else if (active) begin
        if (q_end) begin
          qcnt  <= '0;
          phase <= phase + 2'd1;
          if (phase == 2'd3) begin
            bitcnt <= bitcnt + 4'd1;
          end
        end else begin
          qcnt <= qcnt + Q_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shift  <= bit_bus.tx_byte;
      nack_r <= bit_bus.tx_nack;
    end else if (active && bit_end) begin
      shift <= {shift[eeprom_pkg::DATA_W-2:0], 1'b0}; // msb first
    end
    // sample at the end of the third quarter
    if (active && q_end && phase == 2'd2) begin
      if (cmd_r == eeprom_pkg::cmd_recv && !ack_bit) begin
        rx_shift <= {rx_shift[eeprom_pkg::DATA_W-2:0], sda_in};
      end
      if (cmd_r == eeprom_pkg::cmd_send && ack_bit) begin
        rx_ack_r <= !sda_in;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/eeprom_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_seq (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic                          read,
  input  logic [eeprom_pkg::DATA_W-2:0] ctrl_byte,
  input  logic [eeprom_pkg::DATA_W-1:0] word_addr,
  input  logic [eeprom_pkg::DATA_W-1:0] wr_byte,
  i2c_bit_if.master                     bit_bus,
  output logic                          busy,
  output logic                          done,
  output logic                          ack,
  output logic                          err,
  output logic [eeprom_pkg::DATA_W-1:0] rdata
);

  eeprom_pkg::seq_state_t state;
  eeprom_pkg::seq_state_t state_nxt;

  logic                          nack_seen;
  logic [eeprom_pkg::DATA_W-1:0] rx_buf;
  logic                          sent_nack; // last byte sent got no ack

  assign sent_nack = bit_bus.done && !bit_bus.rx_ack;

  // the next command is issued in the done cycle, so commands run back to back
  always_comb begin
    state_nxt       = state;
    bit_bus.cmd     = eeprom_pkg::cmd_none;
    bit_bus.tx_byte = '0;
    case (state)
      eeprom_pkg::seq_idle: begin
        if (start) begin
          state_nxt   = eeprom_pkg::seq_write_start;
          bit_bus.cmd = eeprom_pkg::cmd_start;
        end
      end
      eeprom_pkg::seq_write_start: begin
        if (bit_bus.done) begin
          state_nxt       = eeprom_pkg::seq_ctrl_write;
          bit_bus.cmd     = eeprom_pkg::cmd_send;
          bit_bus.tx_byte = {ctrl_byte, 1'b0};
        end
      end
      eeprom_pkg::seq_ctrl_write: begin
        if (sent_nack) begin
          state_nxt   = eeprom_pkg::seq_stop;
          bit_bus.cmd = eeprom_pkg::cmd_stop;
        end else if (bit_bus.done) begin
          state_nxt       = eeprom_pkg::seq_addr_write;
          bit_bus.cmd     = eeprom_pkg::cmd_send;
          bit_bus.tx_byte = word_addr;
        end
      end
      eeprom_pkg::seq_addr_write: begin
        if (sent_nack) begin
          state_nxt   = eeprom_pkg::seq_stop;
          bit_bus.cmd = eeprom_pkg::cmd_stop;
        end else if (bit_bus.done && read) begin
          state_nxt   = eeprom_pkg::seq_read_start; // repeated start
          bit_bus.cmd = eeprom_pkg::cmd_start;
        end else if (bit_bus.done) begin
          state_nxt       = eeprom_pkg::seq_data_write;
          bit_bus.cmd     = eeprom_pkg::cmd_send;
          bit_bus.tx_byte = wr_byte;
        end
      end
      eeprom_pkg::seq_data_write,
      eeprom_pkg::seq_data_read: begin
        if (bit_bus.done) begin
          state_nxt   = eeprom_pkg::seq_stop;
          bit_bus.cmd = eeprom_pkg::cmd_stop;
        end
      end
      eeprom_pkg::seq_read_start: begin
        if (bit_bus.done) begin
          state_nxt       = eeprom_pkg::seq_ctrl_read;
          bit_bus.cmd     = eeprom_pkg::cmd_send;
          bit_bus.tx_byte = {ctrl_byte, 1'b1};
        end
      end
      eeprom_pkg::seq_ctrl_read: begin
        if (sent_nack) begin
          state_nxt   = eeprom_pkg::seq_stop;
          bit_bus.cmd = eeprom_pkg::cmd_stop;
        end else if (bit_bus.done) begin
          state_nxt   = eeprom_pkg::seq_data_read;
          bit_bus.cmd = eeprom_pkg::cmd_recv;
        end
      end
      eeprom_pkg::seq_stop: begin
        if (bit_bus.done) begin
          state_nxt = eeprom_pkg::seq_ackn;
        end
      end
      eeprom_pkg::seq_ackn: state_nxt = eeprom_pkg::seq_idle;
      default:              state_nxt = eeprom_pkg::seq_idle;
    endcase
  end

  assign bit_bus.tx_nack = 1'b1; // single byte read where the master never acks

  assign busy = start || (state != eeprom_pkg::seq_idle);
  assign done = (state == eeprom_pkg::seq_ackn);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= eeprom_pkg::seq_idle;
      nack_seen <= 1'b0;
      ack       <= 1'b0;
      err       <= 1'b0;
    end else begin
      state <= state_nxt;
      ack   <= (state_nxt == eeprom_pkg::seq_ackn);
      err   <= (state_nxt == eeprom_pkg::seq_ackn) && nack_seen;
      if (start) begin
        nack_seen <= 1'b0;
      end else if (sent_nack && (state == eeprom_pkg::seq_ctrl_write ||
                                 state == eeprom_pkg::seq_addr_write ||
                                 state == eeprom_pkg::seq_data_write ||
                                 state == eeprom_pkg::seq_ctrl_read)) begin
        nack_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == eeprom_pkg::seq_data_read && bit_bus.done) begin
      rx_buf <= bit_bus.rx_byte;
    end
    if (state_nxt == eeprom_pkg::seq_ackn && read) begin
      rdata <= rx_buf; // visible with ack
    end
  end

endmodule

`default_nettype wire

/* logic/eeprom_req.sv */
`timescale 1ns/10ps
`default_nettype none

module eeprom_req (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  wr,
  input  logic                                  rd,
  input  logic [eeprom_pkg::ADDR_W-1:0]         addr,
  input  logic [eeprom_pkg::DATA_W-1:0]         wdata,
  input  logic                                  done,
  input  logic                                  busy,
  output logic                                  start,
  output logic                                  read,
  output logic [eeprom_pkg::DATA_W-2:0]         ctrl_byte,
  output logic [eeprom_pkg::DATA_W-1:0]         word_addr,
  output logic [eeprom_pkg::DATA_W-1:0]         wr_byte
);

  logic pending; // request handed over until done
  logic accept;

  // strobes during a transfer are dropped
  assign accept = (wr || rd) && !busy && !pending;

  always_ff @(posedge clk) begin
    if (rst) begin
      start   <= 1'b0;
      pending <= 1'b0;
    end else begin
      start <= accept;
      if (accept) begin
        pending <= 1'b1;
      end else if (done) begin
        pending <= 1'b0;
      end
    end
  end

  // request fields held until the next accepted strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      read      <= !wr; // wr wins over rd
      ctrl_byte <= {eeprom_pkg::DEV_ID,
                    addr[eeprom_pkg::ADDR_W-1 -: eeprom_pkg::BLK_W]};
      word_addr <= addr[eeprom_pkg::DATA_W-1:0];
      wr_byte   <= wdata;
    end
  end

endmodule

`default_nettype wire

/* logic/i2c_bit_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface i2c_bit_if;

  eeprom_pkg::bit_cmd_t cmd;
  logic [eeprom_pkg::DATA_W-1:0] tx_byte;
  logic tx_nack; // ack value sent after a received byte

  logic ready;
  logic done;
  logic [eeprom_pkg::DATA_W-1:0] rx_byte;
  logic rx_ack; // slave pulled sda low

  modport master (
    output cmd,
    output tx_byte,
    output tx_nack,
    input  ready,
    input  done,
    input  rx_byte,
    input  rx_ack
  );

  modport engine (
    input  cmd,
    input  tx_byte,
    input  tx_nack,
    output ready,
    output done,
    output rx_byte,
    output rx_ack
  );

endinterface

`default_nettype wire

/* logic/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

  localparam int ADDR_W = 11;
  localparam int DATA_W = 8;
  // block bits sit above the word address
  localparam int BLK_W = ADDR_W - DATA_W;

  localparam logic [3:0] DEV_ID = 4'b1010;

  // one-hot sequencer states
  typedef enum logic [9:0] {
    seq_idle        = 10'b00_0000_0001,
    seq_write_start = 10'b00_0000_0010,
    seq_ctrl_write  = 10'b00_0000_0100,
    seq_addr_write  = 10'b00_0000_1000,
    seq_data_write  = 10'b00_0001_0000,
    seq_read_start  = 10'b00_0010_0000,
    seq_ctrl_read   = 10'b00_0100_0000,
    seq_data_read   = 10'b00_1000_0000,
    seq_stop        = 10'b01_0000_0000,
    seq_ackn        = 10'b10_0000_0000
  } seq_state_t;

  // bit engine commands
  typedef enum logic [2:0] {
    cmd_none  = 3'd0,
    cmd_start = 3'd1,
    cmd_stop  = 3'd2,
    cmd_send  = 3'd3,
    cmd_recv  = 3'd4
  } bit_cmd_t;

endpackage

`default_nettype wire
